// File: quark_defs.svh
// ----------------------------------------------------------------------
// width and reset constants for the Quark RV32I core
// include this file wherever the widths or the reset address are needed
// ----------------------------------------------------------------------
`ifndef QUARK_DEFS_SVH
`define QUARK_DEFS_SVH

// data path and register width
`define QUARK_XLEN 32

// internal program counter and address adder width, zero-extended on the bus
`define QUARK_ADDR_WIDTH 24

// first fetch address after reset
`define QUARK_RESET_ADDR 32'h0000_0000

// size of the register file
`define QUARK_NUM_REGS 32

`endif

// File: quarkPkg.sv
// ----------------------------------------------------------------------
// shared types of the Quark core: decoded instruction, memory request
// and the one-hot control state; reached through quarkPkg:: names
// ----------------------------------------------------------------------
`default_nettype none

`include "quark_defs.svh"

package quarkPkg;

   // everything the ALU and control need from one instruction word
   typedef struct packed {
      logic isLoad;
      logic isAluImm;
      logic isStore;
      logic isAluReg;
      logic isJal;
      logic isJalr;
      logic isLui;
      logic isAuipc;
      logic isBranch;
      // funct3Is[n] is set when funct3 == n
      logic [7:0] funct3Is;
      // instr[30], sub and sra select
      logic altOp;
      // instr[5], tells register ops from immediate ops
      logic regOp;
      logic [4:0] rdId;
      logic [`QUARK_XLEN-1:0] iImm;
      logic [`QUARK_XLEN-1:0] uImm;
      // offset for the pc adder (J, U or B immediate)
      logic [`QUARK_ADDR_WIDTH-1:0] pcImm;
      // offset for the load/store adder (I or S immediate)
      logic [`QUARK_ADDR_WIDTH-1:0] lsImm;
   } decodedInstr_t;

   // one request to the memory bus
   typedef struct packed {
      logic [31:0] addr;
      logic [`QUARK_XLEN-1:0] wdata;
      logic [3:0] wmask;
      logic rstrb;
   } memReq_t;

   typedef enum logic [3:0] {
      FETCH_INSTR     = 4'b0001,
      WAIT_INSTR      = 4'b0010,
      EXECUTE         = 4'b0100,
      WAIT_ALU_OR_MEM = 4'b1000
   } ctrlState_t;

endpackage

`default_nettype wire

// File: quarkDecoder.sv
// ----------------------------------------------------------------------
// combinational RV32I decoder for the Quark core
// takes the latched instruction (bits 31..2) and builds the class flags,
// one-hot funct3 and the immediates, with pc and load/store offsets
// already chosen so control needs one adder for each
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "quark_defs.svh"

module quarkDecoder (
   input  logic [31:2]             instr,
   output quarkPkg::decodedInstr_t dec
);

   // opcode field without the two constant low bits
   logic [6:2] opcode;

   // immediates cut down to the address width, only the adders use them
   logic [`QUARK_ADDR_WIDTH-1:0] sImm;
   logic [`QUARK_ADDR_WIDTH-1:0] bImm;
   logic [`QUARK_ADDR_WIDTH-1:0] jImm;
   logic [`QUARK_ADDR_WIDTH-1:0] uImmAddr;

   assign opcode = instr[6:2];

   // store offset, split between rd and funct7 fields
   assign sImm = {{(`QUARK_ADDR_WIDTH-11){instr[31]}}, instr[30:25], instr[11:7]};
   // branch offset, always even
   assign bImm = {{(`QUARK_ADDR_WIDTH-12){instr[31]}}, instr[7], instr[30:25],
                  instr[11:8], 1'b0};
   // jal offset, scrambled as the spec lays it out
   assign jImm = {{(`QUARK_ADDR_WIDTH-20){instr[31]}}, instr[19:12], instr[20],
                  instr[30:21], 1'b0};
   // low part of the upper immediate for auipc
   assign uImmAddr = {instr[`QUARK_ADDR_WIDTH-1:12], 12'b0};

   always_comb begin
      // instruction classes, at most one is set
      dec.isLoad   = (opcode == 5'b00000);
      dec.isAluImm = (opcode == 5'b00100);
      dec.isStore  = (opcode == 5'b01000);
      dec.isAluReg = (opcode == 5'b01100);
      dec.isJal    = (opcode == 5'b11011);
      dec.isJalr   = (opcode == 5'b11001);
      dec.isLui    = (opcode == 5'b01101);
      dec.isAuipc  = (opcode == 5'b00101);
      dec.isBranch = (opcode == 5'b11000);
      dec.funct3Is = 8'b0000_0001 << instr[14:12];
      dec.altOp    = instr[30];
      dec.regOp    = instr[5];
      dec.rdId     = instr[11:7];
      // full width I and U immediates
      dec.iImm     = {{21{instr[31]}}, instr[30:20]};
      dec.uImm     = {instr[31:12], 12'b0};
      // jal -> J, auipc -> U, anything else -> B (only branches use it then)
      dec.pcImm    = dec.isJal ? jImm : (dec.isAuipc ? uImmAddr : bImm);
      // stores take S, loads take I
      dec.lsImm    = dec.isStore ? sImm : dec.iImm[`QUARK_ADDR_WIDTH-1:0];
   end

endmodule

`default_nettype wire

// File: quarkAlu.sv
// ----------------------------------------------------------------------
// ALU of the Quark core: add/sub, compares and logic ops are combinational,
// shifts run serially one bit per cycle after aluStart while aluBusy is
// high; also gives the branch predicate and the rs1 + operand sum for jalr
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "quark_defs.svh"

module quarkAlu (
   input  logic                    clk,
   input  logic                    reset,
   input  quarkPkg::decodedInstr_t dec,
   input  logic [`QUARK_XLEN-1:0]  rs1,
   input  logic [`QUARK_XLEN-1:0]  rs2,
   input  logic                    aluStart,
   output logic [`QUARK_XLEN-1:0]  aluOut,
   output logic [`QUARK_XLEN-1:0]  aluSum,
   output logic                    predicate,
   output logic                    aluBusy
);

   logic [`QUARK_XLEN-1:0] aluIn2;
   logic [`QUARK_XLEN:0]   aluMinus;
   logic                   lt;
   logic                   ltu;
   logic                   eq;
   logic                   isShift;
   // shift register and remaining amount
   logic [`QUARK_XLEN-1:0] shiftReg;
   logic [4:0]             shamt;

   // register ops and branches compare rs2, everything else uses iImm
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2 : dec.iImm;
   assign aluSum = rs1 + aluIn2;

   // one subtract for sub and all three compare flags
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 1'b1;
   assign ltu = aluMinus[`QUARK_XLEN];
   // signs differ -> rs1 is smaller when it is the negative one
   assign lt  = (rs1[`QUARK_XLEN-1] ^ aluIn2[`QUARK_XLEN-1]) ? rs1[`QUARK_XLEN-1] : ltu;
   assign eq  = (aluMinus[`QUARK_XLEN-1:0] == '0);

   assign isShift = dec.funct3Is[1] | dec.funct3Is[5];
   assign aluBusy = (shamt != '0);

   always_comb begin
      aluOut = '0;
      case (1'b1)
         // sub only for register ops, addi has imm bits in bit 30
         dec.funct3Is[0]: aluOut = (dec.altOp & dec.regOp) ? aluMinus[`QUARK_XLEN-1:0] : aluSum;
         dec.funct3Is[2]: aluOut = {{(`QUARK_XLEN-1){1'b0}}, lt};
         dec.funct3Is[3]: aluOut = {{(`QUARK_XLEN-1){1'b0}}, ltu};
         dec.funct3Is[4]: aluOut = rs1 ^ aluIn2;
         dec.funct3Is[6]: aluOut = rs1 | aluIn2;
         dec.funct3Is[7]: aluOut = rs1 & aluIn2;
         isShift:         aluOut = shiftReg;
         default:         aluOut = '0;
      endcase
   end

   // beq bne blt bge bltu bgeu
   assign predicate = (dec.funct3Is[0] &  eq)  | (dec.funct3Is[1] & ~eq) |
                      (dec.funct3Is[4] &  lt)  | (dec.funct3Is[5] & ~lt) |
                      (dec.funct3Is[6] &  ltu) | (dec.funct3Is[7] & ~ltu);

   always_ff @(posedge clk) begin
      if (!reset) begin
         shamt <= '0;
      end else if (aluStart && isShift) begin
         // load operand, amount comes from rs2 or the immediate
         shiftReg <= rs1;
         shamt    <= aluIn2[4:0];
      end else if (shamt != '0) begin
         shamt <= shamt - 5'd1;
         // sll moves left, srl/sra move right with altOp picking sign fill
         if (dec.funct3Is[1]) begin
            shiftReg <= shiftReg << 1;
         end else begin
            shiftReg <= {dec.altOp & shiftReg[`QUARK_XLEN-1], shiftReg[`QUARK_XLEN-1:1]};
         end
      end
   end

   // a shift only begins right after control starts the ALU
   assert property (@(posedge clk) disable iff (!reset) $rose(aluBusy) |-> $past(aluStart));

endmodule

`default_nettype wire

// File: quarkRegFile.sv
// ----------------------------------------------------------------------
// 32-entry register file of the Quark core with x0 held at zero
// sources are captured into rs1/rs2 on capture, writes land on the next edge
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "quark_defs.svh"

module quarkRegFile (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   capture,
   input  logic [4:0]             rs1Id,
   input  logic [4:0]             rs2Id,
   output logic [`QUARK_XLEN-1:0] rs1,
   output logic [`QUARK_XLEN-1:0] rs2,
   input  logic                   writeEn,
   input  logic [4:0]             rdId,
   input  logic [`QUARK_XLEN-1:0] rdData
);

   logic [`QUARK_XLEN-1:0] regs [`QUARK_NUM_REGS];

   always_ff @(posedge clk) begin
      // x0 is rewritten with zero each cycle
      regs[0] <= '0;
      if (writeEn && rdId != 5'd0) begin
         regs[rdId] <= rdData;
      end
   end

   // operand latch loaded while the instruction word arrives
   always_ff @(posedge clk) begin
      if (!reset) begin
         rs1 <= '0;
         rs2 <= '0;
      end else if (capture) begin
         rs1 <= regs[rs1Id];
         rs2 <= regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

// File: quarkControl.sv
// ----------------------------------------------------------------------
// control of the Quark core: four-state FSM, program counter, bus address,
// store issue and register write-back; registered state, combinational
// outputs, one strobe or mask pulse per access and waits on busy
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "quark_defs.svh"

module quarkControl #(
   parameter logic [31:0] resetAddr = `QUARK_RESET_ADDR
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`QUARK_XLEN-1:0]  memRdata,
   input  logic                    memRbusy,
   input  logic                    memWbusy,
   input  quarkPkg::decodedInstr_t dec,
   input  logic [`QUARK_XLEN-1:0]  rs1,
   input  logic [`QUARK_XLEN-1:0]  rs2,
   input  logic [`QUARK_XLEN-1:0]  aluOut,
   input  logic [`QUARK_XLEN-1:0]  aluSum,
   input  logic                    predicate,
   input  logic                    aluBusy,
   output logic [31:2]             instr,
   output logic                    capture,
   output logic [4:0]              rs1Id,
   output logic [4:0]              rs2Id,
   output logic                    writeEn,
   output logic [`QUARK_XLEN-1:0]  rdData,
   output logic                    aluStart,
   output quarkPkg::memReq_t       memReq
);

   localparam int ZeroExt = `QUARK_XLEN - `QUARK_ADDR_WIDTH;

   quarkPkg::ctrlState_t state;
   logic [`QUARK_ADDR_WIDTH-1:0] pc;
   logic [`QUARK_ADDR_WIDTH-1:0] pcPlus4;
   logic [`QUARK_ADDR_WIDTH-1:0] pcPlusImm;
   logic [`QUARK_ADDR_WIDTH-1:0] lsAddr;
   logic [`QUARK_ADDR_WIDTH-1:0] nextPc;
   logic isAlu;
   logic needToWait;

   assign pcPlus4   = pc + 4;
   // branch, jal and auipc share this adder
   assign pcPlusImm = pc + dec.pcImm;
   assign lsAddr    = rs1[`QUARK_ADDR_WIDTH-1:0] + dec.lsImm;

   assign isAlu      = dec.isAluImm | dec.isAluReg;
   assign needToWait = dec.isLoad | dec.isStore | (isAlu & (dec.funct3Is[1] | dec.funct3Is[5]));

   // jalr drops bit 0 of the target
   assign nextPc = dec.isJalr ? {aluSum[`QUARK_ADDR_WIDTH-1:1], 1'b0} :
                   (dec.isJal | (dec.isBranch & predicate)) ? pcPlusImm : pcPlus4;

   // operands are read straight from the word on the bus
   assign capture = (state == quarkPkg::WAIT_INSTR) & ~memRbusy;
   assign rs1Id   = memRdata[19:15];
   assign rs2Id   = memRdata[24:20];
   assign aluStart = (state == quarkPkg::EXECUTE) & isAlu;

   // write-back in both execute and wait, last write wins for loads and shifts
   assign writeEn = ((state == quarkPkg::EXECUTE) | (state == quarkPkg::WAIT_ALU_OR_MEM)) &
                    ~(dec.isBranch | dec.isStore);

   always_comb begin
      rdData = '0;
      if (dec.isLui)
         rdData = dec.uImm;
      else if (isAlu)
         rdData = aluOut;
      else if (dec.isAuipc)
         rdData = {{ZeroExt{1'b0}}, pcPlusImm};
      else if (dec.isJal | dec.isJalr)
         rdData = {{ZeroExt{1'b0}}, pcPlus4};
      else if (dec.isLoad)
         rdData = memRdata;
   end

   always_comb begin
      // pc while fetching, data address otherwise
      if (state == quarkPkg::FETCH_INSTR || state == quarkPkg::WAIT_INSTR)
         memReq.addr = {{(32-`QUARK_ADDR_WIDTH){1'b0}}, pc};
      else
         memReq.addr = {{(32-`QUARK_ADDR_WIDTH){1'b0}}, lsAddr};
      memReq.wdata = rs2;
      // only word stores, so the mask is all or nothing
      memReq.wmask = {4{(state == quarkPkg::EXECUTE) & dec.isStore}};
      memReq.rstrb = (state == quarkPkg::FETCH_INSTR) | ((state == quarkPkg::EXECUTE) & dec.isLoad);
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= quarkPkg::WAIT_ALU_OR_MEM;
         pc    <= resetAddr[`QUARK_ADDR_WIDTH-1:0];
         instr <= '0;
      end else begin
         case (state)
            quarkPkg::FETCH_INSTR: begin
               state <= quarkPkg::WAIT_INSTR;
            end
            quarkPkg::WAIT_INSTR: begin
               // low two bits are always 11 in RV32I
               if (!memRbusy) begin
                  instr <= memRdata[31:2];
                  state <= quarkPkg::EXECUTE;
               end
            end
            quarkPkg::EXECUTE: begin
               pc    <= nextPc;
               state <= needToWait ? quarkPkg::WAIT_ALU_OR_MEM : quarkPkg::FETCH_INSTR;
            end
            quarkPkg::WAIT_ALU_OR_MEM: begin
               if (!memRbusy && !memWbusy && !aluBusy)
                  state <= quarkPkg::FETCH_INSTR;
            end
            default: begin
               state <= quarkPkg::WAIT_ALU_OR_MEM;
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state));
   assert property (@(posedge clk) disable iff (!reset) !(memReq.rstrb && memReq.wmask != 4'b0));

endmodule

`default_nettype wire

// File: quarkCore.sv
// ----------------------------------------------------------------------
// top of the Quark RV32I core
// one memory bus for instructions and data, driven by control
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "quark_defs.svh"

module quarkCore #(
   parameter logic [31:0] resetAddr = `QUARK_RESET_ADDR
) (
   input  logic                   clk,
   input  logic                   reset,
   output quarkPkg::memReq_t      memReq,
   input  logic [`QUARK_XLEN-1:0] memRdata,
   input  logic                   memRbusy,
   input  logic                   memWbusy
);

   quarkPkg::decodedInstr_t dec;
   logic [`QUARK_XLEN-1:0] rs1;
   logic [`QUARK_XLEN-1:0] rs2;
   logic [`QUARK_XLEN-1:0] aluOut;
   logic [`QUARK_XLEN-1:0] aluSum;
   logic [`QUARK_XLEN-1:0] rdData;
   logic [31:2] instr;
   logic [4:0] rs1Id;
   logic [4:0] rs2Id;
   logic predicate;
   logic aluBusy;
   logic aluStart;
   logic capture;
   logic writeEn;

   quarkDecoder decoder (.instr(instr), .dec(dec));

   quarkAlu alu (
      .clk(clk), .reset(reset), .dec(dec), .rs1(rs1), .rs2(rs2), .aluStart(aluStart),
      .aluOut(aluOut), .aluSum(aluSum), .predicate(predicate), .aluBusy(aluBusy)
   );

   // destination index comes straight from the decoded word
   quarkRegFile regFile (
      .clk(clk), .reset(reset), .capture(capture), .rs1Id(rs1Id), .rs2Id(rs2Id),
      .rs1(rs1), .rs2(rs2), .writeEn(writeEn), .rdId(dec.rdId), .rdData(rdData)
   );

   quarkControl #(.resetAddr(resetAddr)) control (
      .clk(clk), .reset(reset), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .dec(dec), .rs1(rs1), .rs2(rs2), .aluOut(aluOut),
      .aluSum(aluSum), .predicate(predicate), .aluBusy(aluBusy), .instr(instr),
      .capture(capture), .rs1Id(rs1Id), .rs2Id(rs2Id), .writeEn(writeEn),
      .rdData(rdData), .aluStart(aluStart), .memReq(memReq)
   );

endmodule

`default_nettype wire

// File: tbQuark.sv
// ----------------------------------------------------------------------
// testbench for the Quark core: clock, reset, a word memory with random
// busy stretches and a hand-encoded RV32I program whose stores are
// checked against values worked out here from the RV32I rules
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbQuark;

   localparam int CycleLimit = 4000;
   localparam logic [31:0] ResetAddr = 32'h0000_0000;
   localparam logic [31:0] DataBase = 32'h0000_0200;
   localparam logic [31:0] LoadAddr = 32'h0000_0300;
   localparam logic [31:0] TakenMark = 32'h0000_05a5;
   localparam logic [31:0] NotTakenMark = 32'h0000_03c3;
   localparam logic [31:0] Nop = 32'h0000_0013;

   logic clk = 1'b0;
   logic reset = 1'b0;
   quarkPkg::memReq_t memReq;
   logic [31:0] memRdata = '0;
   logic memRbusy = 1'b0;
   logic memWbusy = 1'b0;

   // 1 KB of words, program from 0, data from DataBase
   logic [31:0] mem [256];
   bit noFetch [256];
   // words whose accesses always get at least one busy cycle
   bit slowWord [256];
   int writeCount [256];
   logic [31:0] writeVal [256];
   integer seed = 19756;
   int busyLeft = 0;
   int cycleCount = 0;
   int badFetch = 0;
   int badMask = 0;
   int totalWrites = 0;
   int resetViolations = 0;
   int passes = 0;
   int errors = 0;
   logic done = 1'b0;
   logic seenFirst = 1'b0;
   logic [31:0] firstAddr = '0;
   logic [31:0] haltAddr = '0;
   int progIdx = 0;
   // expected stores with one entry per executed sw
   string expName [32];
   int expOff [32];
   logic [31:0] expVal [32];
   int nExp = 0;
   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] loadWord;
   logic [4:0] shamt;

   quarkCore #(.resetAddr(ResetAddr)) dut (
      .clk(clk), .reset(reset), .memReq(memReq), .memRdata(memRdata),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   initial begin
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   // instruction formats
   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   // sw only
   function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
         input logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // branch outcome by funct3 for the two compared register values
   function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] x,
         input logic [31:0] y);
      case (f3)
         3'd0: return x == y;
         3'd1: return x != y;
         3'd4: return $signed(x) < $signed(y);
         3'd5: return $signed(x) >= $signed(y);
         3'd6: return x < y;
         default: return x >= y;
      endcase
   endfunction

   // busy cycles for one access, never zero on a slow word
   function automatic int drawStall(input logic [31:0] addr);
      int n;
      n = {$random(seed)} % 4;
      if (slowWord[addr[9:2]] && n == 0) begin
         n = 1;
      end
      return n;
   endfunction

   task automatic emit(input logic [31:0] word);
      mem[progIdx] = word;
      progIdx++;
   endtask

   task automatic expectStore(input string name, input int off, input logic [31:0] val);
      expName[nExp] = name;
      expOff[nExp] = off;
      expVal[nExp] = val;
      nExp++;
   endtask

   // lui + addi with the upper part rounded for the signed low 12 bits
   task automatic loadConst(input logic [4:0] rd, input logic [31:0] val);
      logic [31:0] hi;
      hi = (val + 32'h800) >> 12;
      emit(uType(hi[19:0], rd, 7'b0110111));
      emit(iType(val[11:0], rd, 3'b000, rd, 7'b0010011));
   endtask

   // op into x5, then sw x5 to its data slot
   task automatic aluCase(input string name, input logic [6:0] f7, input logic [2:0] f3,
         input logic [4:0] rs2, input int off, input logic [31:0] val);
      emit(rType(f7, rs2, 5'd1, f3, 5'd5));
      emit(sType(off[11:0], 5'd5, 5'd20));
      expectStore(name, off, val);
   endtask

   // taken path jumps over the not-taken store and its jal
   task automatic branchCase(input string name, input logic [2:0] f3, input logic [4:0] rsA,
         input logic [4:0] rsB, input int off);
      logic [31:0] x;
      logic [31:0] y;
      x = (rsA == 5'd1) ? opA : opB;
      y = (rsB == 5'd1) ? opA : opB;
      emit(bType(13'd12, rsB, rsA, f3));
      emit(sType(off[11:0], 5'd11, 5'd20));
      emit(jType(21'd8, 5'd0));
      emit(sType(off[11:0], 5'd10, 5'd20));
      expectStore(name, off, branchTaken(f3, x, y) ? TakenMark : NotTakenMark);
   endtask

   // opA < 0 <= opB, so each pair gives one taken and one not taken run
   task automatic branchPair(input string name, input logic [2:0] f3, input int off);
      if (f3 < 3'd4) begin
         branchCase({name, "_equal"}, f3, 5'd1, 5'd1, off);
         branchCase({name, "_differ"}, f3, 5'd1, 5'd2, off + 4);
      end else begin
         branchCase({name, "_neg_pos"}, f3, 5'd1, 5'd2, off);
         branchCase({name, "_pos_neg"}, f3, 5'd2, 5'd1, off + 4);
      end
   endtask

   task automatic buildProgram();
      logic [31:0] at;
      int first;
      for (int i = 0; i < 256; i++) begin
         mem[i] = 32'ha500_0000 | (i * 4);
      end
      mem[LoadAddr[9:2]] = loadWord;
      loadConst(5'd1, opA);
      loadConst(5'd2, opB);
      emit(iType(DataBase[11:0], 5'd0, 3'b000, 5'd20, 7'b0010011));
      emit(iType(TakenMark[11:0], 5'd0, 3'b000, 5'd10, 7'b0010011));
      emit(iType(NotTakenMark[11:0], 5'd0, 3'b000, 5'd11, 7'b0010011));
      aluCase("add", 7'h00, 3'd0, 5'd2, 0, opA + opB);
      aluCase("sub", 7'h20, 3'd0, 5'd2, 4, opA - opB);
      aluCase("slt", 7'h00, 3'd2, 5'd2, 8, ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0);
      aluCase("sltu", 7'h00, 3'd3, 5'd2, 12, (opA < opB) ? 32'd1 : 32'd0);
      aluCase("xor", 7'h00, 3'd4, 5'd2, 16, opA ^ opB);
      aluCase("or", 7'h00, 3'd6, 5'd2, 20, opA | opB);
      aluCase("and", 7'h00, 3'd7, 5'd2, 24, opA & opB);
      // amount in x3
      first = progIdx;
      emit(iType({7'd0, shamt}, 5'd0, 3'b000, 5'd3, 7'b0010011));
      aluCase("sll", 7'h00, 3'd1, 5'd3, 28, opA << shamt);
      aluCase("srl", 7'h00, 3'd5, 5'd3, 32, opA >> shamt);
      aluCase("sra", 7'h20, 3'd5, 5'd3, 36, $signed(opA) >>> shamt);
      // the shift block and its data slots always see a stall
      for (int i = first; i < progIdx; i++) begin
         slowWord[i] = 1'b1;
      end
      for (int i = 28; i <= 36; i += 4) begin
         slowWord[(DataBase + i) >> 2] = 1'b1;
      end
      branchPair("beq", 3'd0, 40);
      branchPair("bne", 3'd1, 48);
      branchPair("blt", 3'd4, 56);
      branchPair("bge", 3'd5, 64);
      branchPair("bltu", 3'd6, 72);
      branchPair("bgeu", 3'd7, 80);
      // jal x6 over one nop
      at = progIdx * 4;
      emit(jType(21'd8, 5'd6));
      noFetch[progIdx] = 1'b1;
      emit(Nop);
      emit(sType(12'd88, 5'd6, 5'd20));
      expectStore("jal_link", 88, at + 4);
      // auipc x7, then jalr x8 to x7 + 12
      at = progIdx * 4;
      emit(uType(20'h0, 5'd7, 7'b0010111));
      emit(iType(12'd12, 5'd7, 3'b000, 5'd8, 7'b1100111));
      noFetch[progIdx] = 1'b1;
      emit(Nop);
      emit(sType(12'd92, 5'd8, 5'd20));
      expectStore("jalr_link", 92, at + 8);
      at = progIdx * 4;
      emit(uType(20'h00345, 5'd9, 7'b0010111));
      emit(sType(12'd96, 5'd9, 5'd20));
      expectStore("auipc", 96, at + 32'h0034_5000);
      // lw from LoadAddr and store it back
      emit(iType(LoadAddr[11:0] - DataBase[11:0], 5'd20, 3'b010, 5'd12, 7'b0000011));
      emit(sType(12'd100, 5'd12, 5'd20));
      expectStore("load_store_back", 100, loadWord);
      haltAddr = progIdx * 4;
      emit(jType(21'd0, 5'd0));
   endtask

   // each strobe to the memory starts a busy stretch of 0 to 3 cycles
   always @(posedge clk) begin : memModel
      int stall;
      if (reset) begin
         if (memReq.rstrb) begin
            stall = drawStall(memReq.addr);
            memRdata <= mem[memReq.addr[9:2]];
            memRbusy <= (stall != 0);
            busyLeft <= stall;
            if (!seenFirst) begin
               seenFirst <= 1'b1;
               firstAddr <= memReq.addr;
            end
            if (memReq.addr == haltAddr) begin
               done <= 1'b1;
            end
            if (memReq.addr != LoadAddr) begin
               assert (memReq.addr[1:0] == 2'b00 && memReq.addr <= haltAddr &&
                       !noFetch[memReq.addr[9:2]])
               else begin
                  $display("fetch from 0x%08h, an address the program never reaches",
                           memReq.addr);
                  badFetch <= badFetch + 1;
               end
            end
         end else if (memReq.wmask != 4'b0000) begin
            stall = drawStall(memReq.addr);
            assert (memReq.wmask == 4'b1111)
            else begin
               $display("store to 0x%08h used mask %b, not a full word",
                        memReq.addr, memReq.wmask);
               badMask <= badMask + 1;
            end
            writeVal[memReq.addr[9:2]] <= memReq.wdata;
            writeCount[memReq.addr[9:2]] <= writeCount[memReq.addr[9:2]] + 1;
            totalWrites <= totalWrites + 1;
            memWbusy <= (stall != 0);
            busyLeft <= stall;
         end else if (busyLeft > 1) begin
            busyLeft <= busyLeft - 1;
         end else begin
            busyLeft <= 0;
            memRbusy <= 1'b0;
            memWbusy <= 1'b0;
         end
      end
   end

   task automatic verifyValue(input string name, input logic [31:0] expected,
         input logic [31:0] actual);
      assert (actual === expected) begin
         $display("ok %s = 0x%08h", name, actual);
         passes++;
      end else begin
         $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
         errors++;
      end
   endtask

   // each data slot takes exactly one write
   task automatic verifyStore(input int n);
      int idx;
      idx = (DataBase + expOff[n]) >> 2;
      assert (writeCount[idx] == 1)
      else begin
         $display("%s saw %0d writes at 0x%08h where one store ran", expName[n],
                  writeCount[idx], DataBase + expOff[n]);
         errors++;
      end
      verifyValue(expName[n], expVal[n], writeVal[idx]);
   endtask

   initial begin : main
      opA = $random(seed) | 32'h8000_0000;
      opB = $random(seed) & 32'h7fff_ffff;
      shamt = {$random(seed)} % 32;
      loadWord = $random(seed);
      buildProgram();
      // bus stays quiet while reset is low
      repeat (4) begin
         @(negedge clk);
         assert (memReq.rstrb == 1'b0 && memReq.wmask == 4'b0000)
         else begin
            $display("memory strobe active while reset is low");
            resetViolations++;
         end
      end
      @(posedge clk);
      reset <= 1'b1;
      while (!done && cycleCount < CycleLimit) begin
         @(posedge clk);
      end
      if (!done) begin
         $display("timeout: program did not reach its halt loop within %0d cycles",
                  CycleLimit);
         $display("Simulation failed");
      end else begin
         verifyValue("reset_quiet", 32'd0, resetViolations);
         verifyValue("first_fetch", ResetAddr, firstAddr);
         for (int n = 0; n < nExp; n++) begin
            verifyStore(n);
         end
         verifyValue("store_count", nExp, totalWrites);
         verifyValue("word_mask", 32'd0, badMask);
         verifyValue("fetch_range", 32'd0, badFetch);
         $display("%0d tests passed, %0d failed", passes, errors);
         if (errors == 0) begin
            $display("Simulation passed");
         end else begin
            $display("Simulation failed");
         end
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
quarkPkg.sv
quarkDecoder.sv
quarkAlu.sv
quarkRegFile.sv
quarkControl.sv
quarkCore.sv
tbQuark.sv

// File: Makefile
# Verilator build and run of the Quark core testbench
VERILATOR ?= verilator
TOP       ?= tbQuark
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
